/* sources.f */
logic/lsu_pkg.sv
logic/load_rs.sv
logic/store_queue.sv
logic/mem_port.sv
logic/lsu_top.sv
test/clock_gen.sv
test/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the load/store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module lsu_tb \
  -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0

/* test/lsu_tb.sv */
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int CDB_SIZE    = 2;
  localparam int MEM_WORDS   = 64;
  localparam int NUM_TAGS    = 2 ** ROB_DEPTH;
  // loads and stores over all five tests
  localparam int NUM_OPS     = 6 * 13 + 1 + 8 + 8 + 8;
  localparam int FIXED_WAITS = 60;
  localparam int CYCLE_LIMIT = NUM_OPS * 30 + FIXED_WAITS * 2 + 100;
  localparam logic [31:0] SEED = 32'hebebf502;

  logic         clk;
  logic         rst_n;
  logic         flush;
  logic         load_issue_valid;
  load_issue_t  load_issue;
  logic         store_issue_valid;
  store_issue_t store_issue;
  logic         store_commit;
  cdb_t         cdb_in[CDB_SIZE];
  cdb_t         cdb_out;
  logic         load_full;
  logic         store_full;
  logic [31:0]  araddr;
  logic         arvalid;
  logic         arready = 1'b0;
  logic [31:0]  rdata = '0;
  logic         rvalid = 1'b0;
  logic         rready;
  logic [31:0]  awaddr;
  logic         awvalid;
  logic         awready = 1'b0;
  logic [31:0]  wdata;
  logic [3:0]   wstrb;
  logic         wvalid;
  logic         wready = 1'b0;
  logic         bvalid = 1'b0;
  logic         bready;

  // AXI memory and its model state
  logic [31:0] shadow[MEM_WORDS];
  logic [31:0] ref_mem[MEM_WORDS];
  logic [31:0] mem_rng = SEED;
  logic [31:0] stim_rng;
  logic        ar_hold;
  logic        ar_fire;
  logic        aw_fire;
  logic        w_fire;
  logic        r_fire;
  logic        b_fire;
  logic        rd_pend;
  logic        aw_seen;
  logic        w_seen;
  logic [31:0] rd_addr_q;
  logic [31:0] wr_addr_q;
  logic [31:0] wr_data_q;
  logic [3:0]  wr_strb_q;

  // expected results per rob tag
  logic [31:0] exp_val[NUM_TAGS];
  int          issued[NUM_TAGS];
  int          dropped[NUM_TAGS];
  int          answered[NUM_TAGS] = '{default: 0};
  int          next_tag;
  int          stim_checks;
  int          stim_errors;
  int          cmp_checks = 0;
  int          cmp_errors = 0;
  int          cycles = 0;

  clock_gen i_clock_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  lsu_top #(
    .LOAD_RS_DEPTH(3),
    .STORE_Q_DEPTH(3),
    .CDB_SIZE     (CDB_SIZE)
  ) i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush            (flush),
    .load_issue_valid (load_issue_valid),
    .load_issue       (load_issue),
    .store_issue_valid(store_issue_valid),
    .store_issue      (store_issue),
    .store_commit     (store_commit),
    .cdb_in           (cdb_in),
    .cdb_out          (cdb_out),
    .load_full        (load_full),
    .store_full       (store_full),
    .araddr           (araddr),
    .arvalid          (arvalid),
    .arready          (arready),
    .rdata            (rdata),
    .rvalid           (rvalid),
    .rready           (rready),
    .awaddr           (awaddr),
    .awvalid          (awvalid),
    .awready          (awready),
    .wdata            (wdata),
    .wstrb            (wstrb),
    .wvalid           (wvalid),
    .wready           (wready),
    .bvalid           (bvalid),
    .bready           (bready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // power-on contents mixed from the byte address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]} ^ 32'h8040_2010;
  endfunction

  // expected load value from the addressed word
  function automatic logic [31:0] ref_load(input mem_funct3_e f3, input logic [31:0] addr,
                                           input logic [31:0] word);
    logic [31:0] shifted;
    logic [7:0]  b;
    logic [15:0] h;
    shifted = word >> {addr[1:0], 3'b000};
    b = shifted[7:0];
    h = shifted[15:0];
    case (f3)
      lb_mem:  return {{24{b[7]}}, b};
      lbu_mem: return {24'b0, b};
      lh_mem:  return {{16{h[15]}}, h};
      lhu_mem: return {16'b0, h};
      default: return word;
    endcase
  endfunction

  function automatic logic [31:0] store_merge(input mem_funct3_e f3, input logic [31:0] addr,
                                              input logic [31:0] old, input logic [31:0] data);
    logic [31:0] mask;
    logic [4:0]  shift;
    shift = {addr[1:0], 3'b000};
    case (f3)
      sb_mem:  mask = 32'h0000_00ff << shift;
      sh_mem:  mask = 32'h0000_ffff << shift;
      default: mask = 32'hffff_ffff;
    endcase
    return (old & ~mask) | ((data << shift) & mask);
  endfunction

  function automatic logic is_pending(input int t);
    return issued[t] > answered[t] + dropped[t];
  endfunction

  function automatic int total_errors();
    return stim_errors + cmp_errors;
  endfunction

  // AXI4-Lite slave model driven from the falling edge
  always @(negedge clk) begin
    mem_rng = xorshift32(mem_rng);
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        shadow[i] = fill_word(32'(i) << 2);
      end
      arready = 1'b0;
      awready = 1'b0;
      wready  = 1'b0;
      rvalid  = 1'b0;
      bvalid  = 1'b0;
      {ar_fire, aw_fire, w_fire, r_fire, b_fire} = '0;
      {rd_pend, aw_seen, w_seen} = '0;
    end else begin
      // transfers decided last falling edge took place on the rising edge
      if (r_fire) rvalid = 1'b0;
      if (b_fire) bvalid = 1'b0;
      if (ar_fire) rd_pend = 1'b1;
      if (aw_fire) aw_seen = 1'b1;
      if (w_fire) w_seen = 1'b1;
      if (aw_seen && w_seen) begin
        for (int b = 0; b < 4; b++) begin
          if (wr_strb_q[b]) shadow[wr_addr_q[7:2]][8*b +: 8] = wr_data_q[8*b +: 8];
        end
        aw_seen = 1'b0;
        w_seen  = 1'b0;
        bvalid  = 1'b1;
      end
      if (rd_pend && mem_rng[0]) begin
        rvalid  = 1'b1;
        rdata   = shadow[rd_addr_q[7:2]];
        rd_pend = 1'b0;
      end
      arready = !ar_hold && (mem_rng[1] || mem_rng[2]);
      awready = mem_rng[3] || mem_rng[4];
      wready  = mem_rng[5] || mem_rng[6];
      ar_fire = arvalid && arready;
      aw_fire = awvalid && awready;
      w_fire  = wvalid && wready;
      r_fire  = rvalid && rready;
      b_fire  = bvalid && bready;
      if (ar_fire) rd_addr_q = araddr;
      if (aw_fire) wr_addr_q = awaddr;
      if (w_fire) begin
        wr_data_q = wdata;
        wr_strb_q = wstrb;
      end
    end
  end

  // result checker
  always @(negedge clk) begin
    rob_idx_t t;
    if (rst_n && cdb_out.valid) begin
      t = cdb_out.tag;
      cmp_checks++;
      if (!is_pending(t)) begin
        $display("Unexpected result for tag %0d on cdb_out at time %0t", t, $time);
        cmp_errors++;
      end else begin
        if (cdb_out.value !== exp_val[t]) begin
          $display("Fail at %0t: cdb_out.value (tag %0d) got %h expected %h",
                   $time, t, cdb_out.value, exp_val[t]);
          cmp_errors++;
        end
        answered[t]++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a load or store never finished", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic expect_low(input string name, input logic value);
    stim_checks++;
    if (value !== 1'b0) begin
      $display("Fail at %0t: %s got %b expected 0", $time, name, value);
      stim_errors++;
    end
  endtask

  task automatic issue_load(input mem_funct3_e f3, input int tag, input logic [31:0] base,
                            input logic [31:0] imm, input logic rs1_ready,
                            input rob_idx_t rs1_tag);
    logic [31:0] addr;
    addr = base + imm;
    while (is_pending(tag) || load_full) @(negedge clk);
    load_issue.funct3    = f3;
    load_issue.imm       = imm;
    load_issue.target    = rob_idx_t'(tag);
    load_issue.rs1_tag   = rs1_tag;
    load_issue.rs1_ready = rs1_ready;
    // a waiting base carries junk until the CDB wakes it
    load_issue.rs1_value = rs1_ready ? base : 32'hdead_0000;
    load_issue_valid     = 1'b1;
    exp_val[tag] = ref_load(f3, addr, ref_mem[addr[7:2]]);
    issued[tag]++;
    @(negedge clk);
    load_issue_valid = 1'b0;
  endtask

  // random base with imm making up the rest
  task automatic load_at(input mem_funct3_e f3, input logic [31:0] addr);
    stim_rng = xorshift32(stim_rng);
    issue_load(f3, next_tag, stim_rng, addr - stim_rng, 1'b1, '0);
    next_tag = (next_tag + 1) % NUM_TAGS;
  endtask

  task automatic issue_store(input mem_funct3_e f3, input logic [31:0] addr,
                             input logic [31:0] data);
    while (store_full) @(negedge clk);
    store_issue.funct3 = f3;
    store_issue.addr   = addr;
    store_issue.data   = data;
    store_issue_valid  = 1'b1;
    ref_mem[addr[7:2]] = store_merge(f3, addr, ref_mem[addr[7:2]], data);
    @(negedge clk);
    store_issue_valid = 1'b0;
  endtask

  task automatic wait_load(input int tag);
    while (is_pending(tag)) @(negedge clk);
  endtask

  task automatic wait_all();
    for (int t = 0; t < NUM_TAGS; t++) begin
      wait_load(t);
    end
  endtask

  task automatic report_test(input int num, input string name, input int start);
    if (total_errors() == start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, total_errors() - start);
    end
  endtask

  initial begin
    int          start;
    int          pend;
    logic [31:0] word;
    flush             = 1'b0;
    load_issue_valid  = 1'b0;
    load_issue        = '0;
    store_issue_valid = 1'b0;
    store_issue       = '0;
    store_commit      = 1'b0;
    cdb_in[0]         = '0;
    cdb_in[1]         = '0;
    ar_hold           = 1'b0;
    stim_rng          = SEED;
    next_tag          = 0;
    stim_checks       = 0;
    stim_errors       = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(32'(i) << 2);
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      issued[t]  = 0;
      dropped[t] = 0;
    end
    @(posedge rst_n);
    @(negedge clk);

    // outputs idle straight after reset
    start = total_errors();
    expect_low("arvalid", arvalid);
    expect_low("awvalid", awvalid);
    expect_low("wvalid", wvalid);
    expect_low("bready", bready);
    expect_low("rready", rready);
    expect_low("cdb_out.valid", cdb_out.valid);
    expect_low("load_full", load_full);
    expect_low("store_full", store_full);
    report_test(0, "reset state", start);

    start = total_errors();
    for (int w = 0; w < 6; w++) begin
      stim_rng = xorshift32(stim_rng);
      word = {24'b0, stim_rng[7:2], 2'b00};
      for (int off = 0; off < 4; off++) begin
        load_at(lb_mem, word + 32'(off));
        load_at(lbu_mem, word + 32'(off));
        if (off % 2 == 0) begin
          load_at(lh_mem, word + 32'(off));
          load_at(lhu_mem, word + 32'(off));
        end
      end
      load_at(lw_mem, word);
    end
    wait_all();
    report_test(1, "widths and offsets", start);

    // base arrives on lane 1 while lane 0 carries another tag
    start = total_errors();
    issue_load(lh_mem, 2, 32'h7c, 32'h6, 1'b0, 3'd5);
    repeat (12) @(negedge clk);
    stim_checks++;
    if (!is_pending(2)) begin
      $display("Load with tag 2 finished before its base register was broadcast");
      stim_errors++;
    end
    cdb_in[0] = '{valid: 1'b1, tag: 3'd3, value: 32'h10};
    cdb_in[1] = '{valid: 1'b1, tag: 3'd5, value: 32'h7c};
    @(negedge clk);
    cdb_in[0].valid = 1'b0;
    cdb_in[1].valid = 1'b0;
    wait_load(2);
    report_test(2, "rs1 wakeup", start);

    start = total_errors();
    issue_store(sb_mem, 32'ha1, 32'h0000_005a);
    issue_store(sh_mem, 32'ha6, 32'h0000_beef);
    issue_store(sw_mem, 32'ha8, 32'h1234_5678);
    next_tag = 0;
    load_at(lw_mem, 32'ha0);
    load_at(lhu_mem, 32'ha6);
    load_at(lb_mem, 32'hab);
    load_at(lw_mem, 32'hb0);
    load_at(lbu_mem, 32'hb5);
    wait_load(3);
    wait_load(4);
    for (int t = 0; t < 3; t++) begin
      stim_checks++;
      if (!is_pending(t)) begin
        $display("Load with tag %0d finished before the store to its word committed", t);
        stim_errors++;
      end
    end
    repeat (3) begin
      store_commit = 1'b1;
      @(negedge clk);
      store_commit = 1'b0;
    end
    wait_all();
    for (int k = 40; k < 43; k++) begin
      stim_checks++;
      if (shadow[k] !== ref_mem[k]) begin
        $display("Fail at %0t: shadow[%0d] got %h expected %h", $time, k, shadow[k], ref_mem[k]);
        stim_errors++;
      end
    end
    report_test(3, "store then load", start);

    start = total_errors();
    ar_hold  = 1'b1;
    next_tag = 0;
    for (int k = 0; k < NUM_TAGS; k++) begin
      stim_rng = xorshift32(stim_rng);
      word = {24'b0, stim_rng[7:2], 2'b00};
      if (k % 2 == 1) begin
        load_at(lhu_mem, word + 32'h2);
      end else begin
        load_at(lw_mem, word);
      end
    end
    stim_checks++;
    if (load_full !== 1'b1) begin
      $display("Fail at %0t: load_full got %b expected 1", $time, load_full);
      stim_errors++;
    end
    repeat (5) @(negedge clk);
    pend = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (is_pending(t)) pend++;
    end
    stim_checks++;
    if (pend != NUM_TAGS) begin
      $display("Loads finished while arready was held low, %0d still waiting", pend);
      stim_errors++;
    end
    ar_hold = 1'b0;
    wait_all();
    report_test(4, "back-pressure", start);

    start = total_errors();
    ar_hold  = 1'b1;
    next_tag = 0;
    for (int k = 0; k < 4; k++) begin
      load_at(lw_mem, 32'(k) << 4);
    end
    repeat (3) @(negedge clk);
    flush = 1'b1;
    for (int t = 0; t < 4; t++) begin
      dropped[t]++;
    end
    @(negedge clk);
    flush   = 1'b0;
    ar_hold = 1'b0;
    // any flushed tag seen here counts as unexpected
    repeat (30) @(negedge clk);
    for (int k = 0; k < 4; k++) begin
      load_at(lb_mem, (32'(k) << 3) + 32'h41);
    end
    wait_all();
    report_test(5, "flush", start);

    $display("checks %0d, errors %0d", stim_checks + cmp_checks, total_errors());
    if (total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for four rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`default_nettype none

module lsu_top #(
  parameter int LOAD_RS_DEPTH = 3,
  parameter int STORE_Q_DEPTH = 3,
  parameter int CDB_SIZE      = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  load_issue_valid,
  input  lsu_pkg::load_issue_t  load_issue,
  input  logic                  store_issue_valid,
  input  lsu_pkg::store_issue_t store_issue,
  input  logic                  store_commit,
  input  lsu_pkg::cdb_t         cdb_in[CDB_SIZE],
  output lsu_pkg::cdb_t         cdb_out,
  output logic                  load_full,
  output logic                  store_full,
  output logic [31:0]           araddr,
  output logic                  arvalid,
  input  logic                  arready,
  input  logic [31:0]           rdata,
  input  logic                  rvalid,
  output logic                  rready,
  output logic [31:0]           awaddr,
  output logic                  awvalid,
  input  logic                  awready,
  output logic [31:0]           wdata,
  output logic [3:0]            wstrb,
  output logic                  wvalid,
  input  logic                  wready,
  input  logic                  bvalid,
  output logic                  bready
);

  logic [STORE_Q_DEPTH-1:0] sq_head;
  logic [STORE_Q_DEPTH:0]   sq_count;
  logic [31:0]              sq_addr[2**STORE_Q_DEPTH];
  logic                     sq_valid[2**STORE_Q_DEPTH];
  logic                     store_drain;
  logic                     rd_req;
  logic [31:0]              rd_addr;
  logic [LOAD_RS_DEPTH-1:0] rd_idx;
  logic                     rd_done;
  logic [LOAD_RS_DEPTH-1:0] rd_done_idx;
  logic [31:0]              rd_data;
  logic                     wr_req;
  logic [31:0]              wr_addr;
  logic [31:0]              wr_data;
  logic [3:0]               wr_strb;

  load_rs #(
    .LOAD_RS_DEPTH(LOAD_RS_DEPTH),
    .STORE_Q_DEPTH(STORE_Q_DEPTH),
    .CDB_SIZE     (CDB_SIZE)
  ) i_load_rs (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .issue_valid(load_issue_valid),
    .issue      (load_issue),
    .sq_head    (sq_head),
    .sq_count   (sq_count),
    .store_drain(store_drain),
    .cdb_in     (cdb_in),
    .sq_addr    (sq_addr),
    .sq_valid   (sq_valid),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_idx     (rd_idx),
    .rd_done    (rd_done),
    .rd_done_idx(rd_done_idx),
    .rd_data    (rd_data),
    .cdb_out    (cdb_out),
    .full       (load_full)
  );

  store_queue #(
    .STORE_Q_DEPTH(STORE_Q_DEPTH)
  ) i_store_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .issue_valid(store_issue_valid),
    .issue      (store_issue),
    .commit     (store_commit),
    .store_drain(store_drain),
    .head       (sq_head),
    .count      (sq_count),
    .slot_addr  (sq_addr),
    .slot_valid (sq_valid),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_strb    (wr_strb),
    .full       (store_full)
  );

  mem_port #(
    .LOAD_RS_DEPTH(LOAD_RS_DEPTH)
  ) i_mem_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_idx     (rd_idx),
    .rd_done    (rd_done),
    .rd_done_idx(rd_done_idx),
    .rd_data    (rd_data),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_strb    (wr_strb),
    .store_drain(store_drain),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

endmodule

`default_nettype wire

/* logic/mem_port.sv */
`default_nettype none

module mem_port #(
  parameter int LOAD_RS_DEPTH = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     rd_req,
  input  logic [31:0]              rd_addr,
  input  logic [LOAD_RS_DEPTH-1:0] rd_idx,
  output logic                     rd_done,
  output logic [LOAD_RS_DEPTH-1:0] rd_done_idx,
  output logic [31:0]              rd_data,
  input  logic                     wr_req,
  input  logic [31:0]              wr_addr,
  input  logic [31:0]              wr_data,
  input  logic [3:0]               wr_strb,
  output logic                     store_drain,
  output logic [31:0]              araddr,
  output logic                     arvalid,
  input  logic                     arready,
  input  logic [31:0]              rdata,
  input  logic                     rvalid,
  output logic                     rready,
  output logic [31:0]              awaddr,
  output logic                     awvalid,
  input  logic                     awready,
  output logic [31:0]              wdata,
  output logic [3:0]               wstrb,
  output logic                     wvalid,
  input  logic                     wready,
  input  logic                     bvalid,
  output logic                     bready
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_resp
  } state_e;

  state_e                   state;
  logic                     is_read;
  logic                     discard;
  logic                     aw_done;
  logic                     w_done;
  logic                     aw_fire;
  logic                     w_fire;
  logic [31:0]              addr_q;
  logic [31:0]              data_q;
  logic [3:0]               strb_q;
  logic [LOAD_RS_DEPTH-1:0] idx_q;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      is_read <= 1'b0;
      discard <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // loads go first
          if (rd_req) begin
            is_read <= 1'b1;
            discard <= flush;
            state   <= st_read;
          end else if (wr_req) begin
            is_read <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= st_write;
          end
        end
        st_read: begin
          if (flush) begin
            discard <= 1'b1;
          end
          if (arready) begin
            state <= st_resp;
          end
        end
        st_write: begin
          if (aw_fire) begin
            aw_done <= 1'b1;
          end
          if (w_fire) begin
            w_done <= 1'b1;
          end
          if ((aw_done || aw_fire) && (w_done || w_fire)) begin
            state <= st_resp;
          end
        end
        default: begin
          if (flush) begin
            discard <= 1'b1;
          end
          if (is_read ? rvalid : bvalid) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // request payload, word aligned
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      if (rd_req) begin
        addr_q <= {rd_addr[31:2], 2'b00};
        idx_q  <= rd_idx;
      end else if (wr_req) begin
        addr_q <= {wr_addr[31:2], 2'b00};
        data_q <= wr_data;
        strb_q <= wr_strb;
      end
    end
  end

  assign araddr  = addr_q;
  assign arvalid = state == st_read;
  assign rready  = state == st_resp && is_read;
  assign awaddr  = addr_q;
  assign awvalid = state == st_write && !aw_done;
  assign wdata   = data_q;
  assign wstrb   = strb_q;
  assign wvalid  = state == st_write && !w_done;
  assign bready  = state == st_resp && !is_read;

  // flushed reads finish silently
  assign rd_done     = rready && rvalid && !discard;
  assign rd_done_idx = idx_q;
  assign rd_data     = rdata;
  assign store_drain = bready && bvalid;

endmodule

`default_nettype wire

/* logic/store_queue.sv */
`default_nettype none

module store_queue #(
  parameter int STORE_Q_DEPTH = 3
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     issue_valid,
  input  lsu_pkg::store_issue_t    issue,
  input  logic                     commit,
  input  logic                     store_drain,
  output logic [STORE_Q_DEPTH-1:0] head,
  output logic [STORE_Q_DEPTH:0]   count,
  output logic [31:0]              slot_addr[2**STORE_Q_DEPTH],
  output logic                     slot_valid[2**STORE_Q_DEPTH],
  output logic                     wr_req,
  output logic [31:0]              wr_addr,
  output logic [31:0]              wr_data,
  output logic [3:0]               wr_strb,
  output logic                     full
);
  import lsu_pkg::*;

  localparam int NUM_SLOTS = 2 ** STORE_Q_DEPTH;

  logic [STORE_Q_DEPTH-1:0] tail;
  logic [STORE_Q_DEPTH:0]   cmt_count;
  logic [STORE_Q_DEPTH:0]   cmt_next;
  logic                     push;
  mem_word_u                lane;
  logic [3:0]               strb;
  logic [31:0]              data_q[NUM_SLOTS];
  logic [3:0]               strb_q[NUM_SLOTS];

  assign full     = count == (STORE_Q_DEPTH+1)'(NUM_SLOTS);
  assign push     = issue_valid && !full;
  assign cmt_next = cmt_count + (STORE_Q_DEPTH+1)'(commit) - (STORE_Q_DEPTH+1)'(store_drain);

  // place store data in its byte lane
  always_comb begin
    lane = '0;
    strb = '0;
    case (issue.funct3)
      sb_mem: begin
        lane.bytes[issue.addr[1:0]] = issue.data[7:0];
        strb = 4'b0001 << issue.addr[1:0];
      end
      sh_mem: begin
        lane.halves[issue.addr[1]] = issue.data[15:0];
        strb = 4'b0011 << {issue.addr[1], 1'b0};
      end
      default: begin
        lane = issue.data;
        strb = 4'b1111;
      end
    endcase
  end

  always_comb begin
    logic [STORE_Q_DEPTH-1:0] offset;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      offset        = (STORE_Q_DEPTH)'(i) - head;
      slot_valid[i] = {1'b0, offset} < count;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      cmt_count <= '0;
    end else begin
      if (store_drain) begin
        head <= head + 1'b1;
      end
      cmt_count <= cmt_next;
      if (flush) begin
        // committed stores survive
        tail  <= head + cmt_count[STORE_Q_DEPTH-1:0] + (STORE_Q_DEPTH)'(commit);
        count <= cmt_next;
      end else begin
        if (push) begin
          tail <= tail + 1'b1;
        end
        count <= count + (STORE_Q_DEPTH+1)'(push) - (STORE_Q_DEPTH+1)'(store_drain);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      slot_addr[tail] <= issue.addr;
      data_q[tail]    <= lane;
      strb_q[tail]    <= strb;
    end
  end

  // head drains once committed
  assign wr_req  = cmt_count != '0;
  assign wr_addr = slot_addr[head];
  assign wr_data = data_q[head];
  assign wr_strb = strb_q[head];

endmodule

`default_nettype wire

/* logic/load_rs.sv */
`default_nettype none

module load_rs #(
  parameter int LOAD_RS_DEPTH = 3,
  parameter int STORE_Q_DEPTH = 3,
  parameter int CDB_SIZE      = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     issue_valid,
  input  lsu_pkg::load_issue_t     issue,
  input  logic [STORE_Q_DEPTH-1:0] sq_head,
  input  logic [STORE_Q_DEPTH:0]   sq_count,
  input  logic                     store_drain,
  input  lsu_pkg::cdb_t            cdb_in[CDB_SIZE],
  input  logic [31:0]              sq_addr[2**STORE_Q_DEPTH],
  input  logic                     sq_valid[2**STORE_Q_DEPTH],
  output logic                     rd_req,
  output logic [31:0]              rd_addr,
  output logic [LOAD_RS_DEPTH-1:0] rd_idx,
  input  logic                     rd_done,
  input  logic [LOAD_RS_DEPTH-1:0] rd_done_idx,
  input  logic [31:0]              rd_data,
  output lsu_pkg::cdb_t            cdb_out,
  output logic                     full
);
  import lsu_pkg::*;

  localparam int NUM_ENTRIES = 2 ** LOAD_RS_DEPTH;
  localparam int SQ_SLOTS    = 2 ** STORE_Q_DEPTH;

  logic [NUM_ENTRIES-1:0]   busy;
  logic [NUM_ENTRIES-1:0]   ord_ok;
  load_issue_t              ent[NUM_ENTRIES];
  logic [STORE_Q_DEPTH-1:0] sq_tail_q[NUM_ENTRIES];
  logic [STORE_Q_DEPTH:0]   sq_cnt_q[NUM_ENTRIES];
  logic [31:0]              eff_addr[NUM_ENTRIES];
  logic [LOAD_RS_DEPTH-1:0] sel_ptr;
  logic [LOAD_RS_DEPTH-1:0] free_idx;
  logic                     free_found;
  logic                     do_issue;
  mem_word_u                rd_word;
  logic [31:0]              done_addr;
  logic [7:0]               done_byte;
  logic [15:0]              done_half;
  logic [31:0]              done_value;

  // true once every store older than the load is gone or hits another word
  function automatic logic older_clear(input logic [STORE_Q_DEPTH-1:0] tail,
                                       input logic [STORE_Q_DEPTH:0]   cnt,
                                       input logic [31:0]              addr);
    logic                     clear;
    logic                     stop;
    logic [STORE_Q_DEPTH-1:0] slot;
    clear = 1'b0;
    stop  = 1'b0;
    for (int j = 0; j <= SQ_SLOTS; j++) begin
      slot = tail - (STORE_Q_DEPTH)'(j + 1);
      if (!stop) begin
        if (cnt == (STORE_Q_DEPTH+1)'(j)) begin
          clear = 1'b1;
          stop  = 1'b1;
        end else if (!sq_valid[slot] || sq_addr[slot][31:2] == addr[31:2]) begin
          stop = 1'b1;
        end
      end
    end
    return clear;
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      eff_addr[i] = ent[i].rs1_value + ent[i].imm;
    end
  end

  // first free slot
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      if (!free_found && !busy[k]) begin
        free_found = 1'b1;
        free_idx   = (LOAD_RS_DEPTH)'(k);
      end
    end
  end

  assign full     = !free_found;
  assign do_issue = issue_valid && free_found;

  // rotating pick, starting after the last completed entry
  always_comb begin
    logic [LOAD_RS_DEPTH-1:0] cand;
    rd_req = 1'b0;
    rd_idx = '0;
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      cand = sel_ptr + (LOAD_RS_DEPTH)'(k);
      if (!rd_req && busy[cand] && ord_ok[cand]) begin
        rd_req = 1'b1;
        rd_idx = cand;
      end
    end
    rd_addr = eff_addr[rd_idx];
  end

  always_comb begin
    rd_word   = rd_data;
    done_addr = eff_addr[rd_done_idx];
    done_byte = rd_word.bytes[done_addr[1:0]];
    done_half = rd_word.halves[done_addr[1]];
    case (ent[rd_done_idx].funct3)
      lb_mem:  done_value = {{24{done_byte[7]}}, done_byte};
      lbu_mem: done_value = {24'b0, done_byte};
      lh_mem:  done_value = {{16{done_half[15]}}, done_half};
      lhu_mem: done_value = {16'b0, done_half};
      default: done_value = rd_word;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= '0;
      ord_ok  <= '0;
      sel_ptr <= '0;
      cdb_out <= '0;
    end else begin
      cdb_out.valid <= rd_done && !flush;
      if (rd_done) begin
        cdb_out.tag   <= ent[rd_done_idx].target;
        cdb_out.value <= done_value;
      end
      if (flush) begin
        busy   <= '0;
        ord_ok <= '0;
      end else begin
        if (do_issue) begin
          busy[free_idx]   <= 1'b1;
          ord_ok[free_idx] <= 1'b0;
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
          if (busy[i] && !ord_ok[i] && ent[i].rs1_ready &&
              older_clear(sq_tail_q[i], sq_cnt_q[i], eff_addr[i])) begin
            ord_ok[i] <= 1'b1;
          end
        end
        if (rd_done) begin
          busy[rd_done_idx]   <= 1'b0;
          ord_ok[rd_done_idx] <= 1'b0;
          sel_ptr             <= rd_done_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_issue) begin
      ent[free_idx]       <= issue;
      sq_tail_q[free_idx] <= sq_head + sq_count[STORE_Q_DEPTH-1:0];
      // a store leaving this cycle is no longer older
      if (store_drain && sq_count != '0) begin
        sq_cnt_q[free_idx] <= sq_count - 1'b1;
      end else begin
        sq_cnt_q[free_idx] <= sq_count;
      end
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (busy[i]) begin
        for (int j = 0; j < CDB_SIZE; j++) begin
          if (cdb_in[j].valid && !ent[i].rs1_ready && cdb_in[j].tag == ent[i].rs1_tag) begin
            ent[i].rs1_ready <= 1'b1;
            ent[i].rs1_value <= cdb_in[j].value;
          end
        end
        if (store_drain && sq_cnt_q[i] != '0) begin
          sq_cnt_q[i] <= sq_cnt_q[i] - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // reorder buffer tag width
  localparam int ROB_DEPTH = 3;

  typedef logic [ROB_DEPTH-1:0] rob_idx_t;

  // RV32I load width codes
  typedef enum logic [2:0] {
    lb_mem  = 3'b000,
    lh_mem  = 3'b001,
    lw_mem  = 3'b010,
    lbu_mem = 3'b100,
    lhu_mem = 3'b101
  } mem_funct3_e;

  // stores share the low three codes
  localparam mem_funct3_e sb_mem = lb_mem;
  localparam mem_funct3_e sh_mem = lh_mem;
  localparam mem_funct3_e sw_mem = lw_mem;

  // one data word seen as bytes or as halves
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } mem_word_u;

  typedef struct packed {
    mem_funct3_e funct3;
    logic [31:0] imm;
    rob_idx_t    target;
    rob_idx_t    rs1_tag;
    logic        rs1_ready;
    logic [31:0] rs1_value;
  } load_issue_t;

  // addr is the byte address, low bits pick the lane
  typedef struct packed {
    mem_funct3_e funct3;
    logic [31:0] addr;
    logic [31:0] data;
  } store_issue_t;

  typedef struct packed {
    logic        valid;
    rob_idx_t    tag;
    logic [31:0] value;
  } cdb_t;

endpackage

`default_nettype wire
